// ==== design/mem_pkg.sv ====
/*
  shared memory widths, request struct and port index helper
*/
`default_nettype none

package mem_pkg;

  // address width of the single bank
  localparam int unsigned AddrWidth = 6;

  // width of one memory word
  localparam int unsigned DataWidth = 16;

  // number of words held by the bank
  localparam int unsigned NumWords = 2 ** AddrWidth;

  // number of request ports the top level is built with by default
  localparam int unsigned NumPortsDefault = 4;

  // one access as it travels from a port through the arbiter to the bank
  // the write flag sits in the top bit and the write data in the low bits
  typedef struct packed {
    logic                 we;
    logic [AddrWidth-1:0] addr;
    logic [DataWidth-1:0] wdata;
  } mem_req_t;

  // width of a port index for a given number of ports
  // a single port still needs one bit so that the index never collapses
  function automatic int unsigned idx_width(input int unsigned num_ports);
    int unsigned width;
    width = (num_ports > 1) ? $clog2(num_ports) : 1;
    return width;
  endfunction

endpackage

`default_nettype wire

// ==== design/mem_req_if.sv ====
/*
  arbitrated request bus between the arbiter tree and the memory bank
*/
`default_nettype none

interface mem_req_if #(
  parameter int unsigned IdxWidth = 2
);

  // request valid from the arbiter root
  logic                           req;
  // bank accepts the request in this cycle
  logic                           gnt;
  // payload of the winning port
  mem_pkg::mem_req_t              req_data;
  // index of the winning port
  logic [IdxWidth-1:0]            idx;
  // read data, valid the cycle after a read transfer
  logic [mem_pkg::DataWidth-1:0]  rdata;

  // arbiter side drives the request and sees the bank response
  modport arb (
    output req, req_data, idx,
    input  gnt, rdata
  );

  // bank side mirrors the arbiter
  modport bank (
    input  req, req_data, idx,
    output gnt, rdata
  );

endinterface

`default_nettype wire

// ==== design/lzc.sv ====
/*
  trailing zero counter
  gives the lowest set index of a request vector
*/
`default_nettype none

module lzc #(
  parameter int unsigned NumPorts = 4,
  localparam int unsigned CntWidth = mem_pkg::idx_width(NumPorts)
) (
  input  logic [NumPorts-1:0] in_i,
  output logic [CntWidth-1:0] cnt_o,
  output logic                empty_o
);

  // scan from the top down so the lowest set bit writes last and wins
  // with no bit set the count stays at zero and empty_o tells the user
  always_comb begin
    cnt_o = '0;
    for (int unsigned i = NumPorts; i > 0; i--) begin
      if (in_i[i-1]) begin
        cnt_o = CntWidth'(i - 1);
      end
    end
  end

  // nothing to count when all bits are clear
  assign empty_o = ~|in_i;

  ////////////////////////////////
  // checks
  ////////////////////////////////

  // a non-empty result must name a bit that is actually set
  // evaluated once the inputs have settled in the time step
  always_comb begin
    assert final (empty_o || in_i[cnt_o])
      else $error("lzc count does not point at a set bit");
  end

endmodule

`default_nettype wire

// ==== design/rr_arb_tree.sv ====
/*
  logarithmic round robin arbitration tree
  fair next priority via two trailing zero counters, flush of the priority
*/
`default_nettype none

module rr_arb_tree #(
  parameter int unsigned NumPorts = 4,
  parameter bit          FairArb  = 1'b1
) (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  logic                             flush_i,
  input  logic              [NumPorts-1:0] req_i,
  output logic              [NumPorts-1:0] gnt_o,
  input  mem_pkg::mem_req_t [NumPorts-1:0] data_i,
  mem_req_if.arb                           bus
);

  localparam int unsigned IdxWidth  = mem_pkg::idx_width(NumPorts);
  localparam int unsigned NumLevels = $clog2(NumPorts);
  localparam int unsigned NumNodes  = 2 ** NumLevels - 1;

  typedef logic [IdxWidth-1:0] idx_t;

  // node 0 is the root, children of node n sit at 2n+1 and 2n+2
  idx_t              [NumNodes-1:0] index_nodes;
  mem_pkg::mem_req_t [NumNodes-1:0] data_nodes;
  logic              [NumNodes-1:0] gnt_nodes;
  logic              [NumNodes-1:0] req_nodes;

  // port with the highest priority in the current cycle
  idx_t rr_q;
  idx_t rr_d;

  // a transfer happens when the root request meets the bank grant
  logic xfer;

  assign bus.req      = req_nodes[0];
  assign bus.req_data = data_nodes[0];
  assign bus.idx      = index_nodes[0];
  assign gnt_nodes[0] = bus.gnt;
  assign xfer         = bus.req & bus.gnt;

  ////////////////////////////////
  // next priority
  ////////////////////////////////

  if (FairArb) begin : gen_fair
    logic [NumPorts-1:0] upper_mask;
    logic [NumPorts-1:0] lower_mask;
    idx_t                upper_idx;
    idx_t                lower_idx;
    logic                upper_empty;
    logic                lower_empty;
    idx_t                next_idx;

    // split the requests into those above the winner and the rest
    for (genvar i = 0; i < NumPorts; i++) begin : gen_mask
      assign upper_mask[i] = (idx_t'(i) > bus.idx) ? req_i[i] : 1'b0;
      assign lower_mask[i] = (idx_t'(i) > bus.idx) ? 1'b0 : req_i[i];
    end

    lzc #(
      .NumPorts ( NumPorts )
    ) i_lzc_upper (
      .in_i    ( upper_mask  ),
      .cnt_o   ( upper_idx   ),
      .empty_o ( upper_empty )
    );

    lzc #(
      .NumPorts ( NumPorts )
    ) i_lzc_lower (
      .in_i    ( lower_mask  ),
      .cnt_o   ( lower_idx   ),
      .empty_o ( lower_empty )
    );

    // take the next request above, else wrap to the lowest one pending
    // with nothing pending at all the priority stays where it is
    always_comb begin
      if (!upper_empty) begin
        next_idx = upper_idx;
      end else if (!lower_empty) begin
        next_idx = lower_idx;
      end else begin
        next_idx = rr_q;
      end
    end

    assign rr_d = xfer ? next_idx : rr_q;
  end else begin : gen_unfair
    // plain rotation by one, wrapping at the last port
    assign rr_d = !xfer ? rr_q :
                  (rr_q == idx_t'(NumPorts - 1)) ? '0 : rr_q + idx_t'(1);
  end

  // the priority only moves on a transfer so back-pressure freezes it
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rr_q <= '0;
    end else if (flush_i) begin
      rr_q <= '0;
    end else begin
      rr_q <= rr_d;
    end
  end

  ////////////////////////////////
  // selector tree
  ////////////////////////////////

  for (genvar level = 0; level < NumLevels; level++) begin : gen_levels
    for (genvar l = 0; l < 2 ** level; l++) begin : gen_nodes
      localparam int unsigned Node  = 2 ** level - 1 + l;
      localparam int unsigned Child = 2 ** (level + 1) - 1 + 2 * l;

      if (level == NumLevels - 1) begin : gen_leaf
        // leaves take the port requests directly, two at a time
        if (2 * l + 1 < NumPorts) begin : gen_pair
          logic sel;

          // right input wins when the left is idle or the priority bit points right
          assign sel = ~req_i[2*l] | (req_i[2*l+1] & rr_q[NumLevels-1-level]);

          assign req_nodes[Node]   = req_i[2*l] | req_i[2*l+1];
          assign index_nodes[Node] = idx_t'(sel);
          assign data_nodes[Node]  = sel ? data_i[2*l+1] : data_i[2*l];
          assign gnt_o[2*l]        = gnt_nodes[Node] & req_i[2*l] & ~sel;
          assign gnt_o[2*l+1]      = gnt_nodes[Node] & req_i[2*l+1] & sel;
        end else if (2 * l < NumPorts) begin : gen_single
          // odd port count leaves one port without a partner
          assign req_nodes[Node]   = req_i[2*l];
          assign index_nodes[Node] = '0;
          assign data_nodes[Node]  = data_i[2*l];
          assign gnt_o[2*l]        = gnt_nodes[Node] & req_i[2*l];
        end else begin : gen_empty
          // leaf beyond the last port never requests
          assign req_nodes[Node]   = 1'b0;
          assign index_nodes[Node] = '0;
          assign data_nodes[Node]  = '0;
        end
      end else begin : gen_inner
        logic sel;

        assign sel = ~req_nodes[Child] | (req_nodes[Child+1] & rr_q[NumLevels-1-level]);

        // the chosen side adds its bit on top of the index from below
        assign req_nodes[Node]   = req_nodes[Child] | req_nodes[Child+1];
        assign index_nodes[Node] = sel ?
          idx_t'({1'b1, index_nodes[Child+1][NumLevels-level-2:0]}) :
          idx_t'({1'b0, index_nodes[Child][NumLevels-level-2:0]});
        assign data_nodes[Node]  = sel ? data_nodes[Child+1] : data_nodes[Child];

        // the grant walks back down the side that won
        assign gnt_nodes[Child]   = gnt_nodes[Node] & ~sel;
        assign gnt_nodes[Child+1] = gnt_nodes[Node] & sel;
      end
    end
  end

  ////////////////////////////////
  // checks
  ////////////////////////////////

  // at most one port is granted per cycle
  assert property (@(posedge clk_i) disable iff (!rst_ni) $onehot0(gnt_o))
    else $error("arbiter granted more than one port");

  // a port grant needs the bank grant and must match the index sent to the bank
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    |gnt_o |-> (bus.gnt && gnt_o[bus.idx]))
    else $error("port grant does not match the bank transfer");

  // any pending port makes the root request
  assert property (@(posedge clk_i) disable iff (!rst_ni) |req_i |-> bus.req)
    else $error("pending request lost in the tree");

endmodule

`default_nettype wire

// ==== design/mem_port.sv ====
/*
  one request port
  holds a single access until granted and returns read data
*/
`default_nettype none

module mem_port (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          req_i,
  input  logic                          we_i,
  input  logic [mem_pkg::AddrWidth-1:0] addr_i,
  input  logic [mem_pkg::DataWidth-1:0] wdata_i,
  output logic                          busy_o,
  output logic                          gnt_o,
  output logic                          rvalid_o,
  output logic [mem_pkg::DataWidth-1:0] rdata_o,
  output logic                          arb_req_o,
  input  logic                          arb_gnt_i,
  output mem_pkg::mem_req_t             arb_data_o,
  input  logic [mem_pkg::DataWidth-1:0] bank_rdata_i
);

  // the access waiting for its grant
  mem_pkg::mem_req_t req_q;
  logic              busy_q;
  // read granted last cycle so the bank data is valid now
  logic              rd_q;
  // last read value kept after the valid cycle
  logic [mem_pkg::DataWidth-1:0] rdata_q;
  logic              accept;

  assign accept = req_i & ~busy_q;

  // busy covers exactly the cycles the request sits at the arbiter
  // it clears on the grant so a read returns while busy is already low
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q <= 1'b0;
      rd_q   <= 1'b0;
    end else begin
      if (accept) begin
        busy_q <= 1'b1;
      end else if (arb_gnt_i) begin
        busy_q <= 1'b0;
      end
      rd_q <= arb_gnt_i & ~req_q.we;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      req_q <= '{we: we_i, addr: addr_i, wdata: wdata_i};
    end
    if (rd_q) begin
      rdata_q <= bank_rdata_i;
    end
  end

  assign busy_o     = busy_q;
  assign arb_req_o  = busy_q;
  assign arb_data_o = req_q;
  assign gnt_o      = arb_gnt_i;
  assign rvalid_o   = rd_q;
  // straight from the bank in the valid cycle and the held copy afterwards
  assign rdata_o    = rd_q ? bank_rdata_i : rdata_q;

  // the outside waits for busy to drop before the next access
  assert property (@(posedge clk_i) disable iff (!rst_ni) req_i |-> !busy_o)
    else $error("request issued while the port is busy");

endmodule

`default_nettype wire

// ==== design/sram_bank.sv ====
/*
  single ported memory bank
  one cycle read latency and one recovery cycle after each write
*/
`default_nettype none

module sram_bank (
  input  logic    clk_i,
  input  logic    rst_ni,
  mem_req_if.bank bus
);

  logic [mem_pkg::DataWidth-1:0] mem_q [mem_pkg::NumWords];
  logic [mem_pkg::DataWidth-1:0] rdata_q;
  // set out of reset and after every write so the bank sits out one cycle
  logic                          recovery_q;
  logic                          xfer;

  assign xfer = bus.req & bus.gnt;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      recovery_q <= 1'b1;
    end else begin
      recovery_q <= xfer & bus.req_data.we;
    end
  end

  // array and read register hold no reset
  always_ff @(posedge clk_i) begin
    if (xfer && bus.req_data.we) begin
      mem_q[bus.req_data.addr] <= bus.req_data.wdata;
    end
    if (xfer && !bus.req_data.we) begin
      rdata_q <= mem_q[bus.req_data.addr];
    end
  end

  // the grant never looks at req so there is no loop through the tree
  assign bus.gnt   = ~recovery_q;
  assign bus.rdata = rdata_q;

  // ports never withdraw so a refused request is still there next cycle
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (bus.req && !bus.gnt) |=> bus.req)
    else $error("request dropped under back-pressure");

endmodule

`default_nettype wire

// ==== design/shared_mem_top.sv ====
/*
  shared memory top level
  request ports, round robin arbiter tree and one memory bank
*/
`default_nettype none

module shared_mem_top #(
  parameter int unsigned NumPorts = mem_pkg::NumPortsDefault,
  parameter bit          FairArb  = 1'b1
) (
  input  logic                                        clk_i,
  input  logic                                        rst_ni,
  input  logic                                        flush_i,
  input  logic [NumPorts-1:0]                         req_i,
  input  logic [NumPorts-1:0]                         we_i,
  input  logic [NumPorts-1:0][mem_pkg::AddrWidth-1:0] addr_i,
  input  logic [NumPorts-1:0][mem_pkg::DataWidth-1:0] wdata_i,
  output logic [NumPorts-1:0]                         busy_o,
  output logic [NumPorts-1:0]                         gnt_o,
  output logic [NumPorts-1:0]                         rvalid_o,
  output logic [NumPorts-1:0][mem_pkg::DataWidth-1:0] rdata_o
);

  localparam int unsigned IdxWidth = mem_pkg::idx_width(NumPorts);

  // port side of the arbiter
  logic              [NumPorts-1:0] arb_req;
  logic              [NumPorts-1:0] arb_gnt;
  mem_pkg::mem_req_t [NumPorts-1:0] arb_data;

  // arbiter to bank
  mem_req_if #(
    .IdxWidth ( IdxWidth )
  ) bank_bus ();

  ////////////////////////////////
  // request ports
  ////////////////////////////////

  for (genvar p = 0; p < NumPorts; p++) begin : gen_ports
    // every port sees the bank read data and keeps it only after its own read
    mem_port i_port (
      .clk_i        ( clk_i          ),
      .rst_ni       ( rst_ni         ),
      .req_i        ( req_i[p]       ),
      .we_i         ( we_i[p]        ),
      .addr_i       ( addr_i[p]      ),
      .wdata_i      ( wdata_i[p]     ),
      .busy_o       ( busy_o[p]      ),
      .gnt_o        ( gnt_o[p]       ),
      .rvalid_o     ( rvalid_o[p]    ),
      .rdata_o      ( rdata_o[p]     ),
      .arb_req_o    ( arb_req[p]     ),
      .arb_gnt_i    ( arb_gnt[p]     ),
      .arb_data_o   ( arb_data[p]    ),
      .bank_rdata_i ( bank_bus.rdata )
    );
  end

  ////////////////////////////////
  // arbiter and bank
  ////////////////////////////////

  rr_arb_tree #(
    .NumPorts ( NumPorts ),
    .FairArb  ( FairArb  )
  ) i_arb (
    .clk_i   ( clk_i    ),
    .rst_ni  ( rst_ni   ),
    .flush_i ( flush_i  ),
    .req_i   ( arb_req  ),
    .gnt_o   ( arb_gnt  ),
    .data_i  ( arb_data ),
    .bus     ( bank_bus )
  );

  sram_bank i_bank (
    .clk_i  ( clk_i    ),
    .rst_ni ( rst_ni   ),
    .bus    ( bank_bus )
  );

endmodule

`default_nettype wire

// ==== bench/mem_checker.sv ====
/*
  testbench checker for the shared memory
  keeps a model of the memory, the per-port requests and the grant fairness
*/
`default_nettype none

module mem_checker #(
  parameter int unsigned NumPorts = 4
) (
  input  logic                                        clk_i,
  input  logic                                        rst_ni,
  input  logic                                        flush_i,
  input  logic                                        fair_en_i,
  input  logic [NumPorts-1:0]                         req_i,
  input  logic [NumPorts-1:0]                         we_i,
  input  logic [NumPorts-1:0][mem_pkg::AddrWidth-1:0] addr_i,
  input  logic [NumPorts-1:0][mem_pkg::DataWidth-1:0] wdata_i,
  input  logic [NumPorts-1:0]                         busy_o,
  input  logic [NumPorts-1:0]                         gnt_o,
  input  logic [NumPorts-1:0]                         rvalid_o,
  input  logic [NumPorts-1:0][mem_pkg::DataWidth-1:0] rdata_o,
  output int                                          err_cnt_o,
  output int                                          flush_hits_o
);

  // model of the bank, filled on write grants
  logic [mem_pkg::DataWidth-1:0] model_mem [mem_pkg::NumWords];
  bit                            model_valid [mem_pkg::NumWords];

  // the access each port accepted and still holds
  logic [NumPorts-1:0]                         held_we;
  logic [NumPorts-1:0][mem_pkg::AddrWidth-1:0] held_addr;
  logic [NumPorts-1:0][mem_pkg::DataWidth-1:0] held_wdata;

  // ports already granted for the access they hold
  logic [NumPorts-1:0]                         granted;

  // reads granted in the previous cycle and the value they must return
  logic [NumPorts-1:0]                         rd_pend;
  logic [NumPorts-1:0]                         rd_known;
  logic [NumPorts-1:0][mem_pkg::DataWidth-1:0] rd_exp;

  logic prev_wr_grant;
  logic prev_flush;

  // grants given to port q while port p was waiting
  int unsigned rival_cnt [NumPorts][NumPorts];

  task automatic report_value(input string sig, input logic [31:0] exp, input logic [31:0] got);
    $display("Error at %0t: %s expected %0h got %0h", $time, sig, exp, got);
    err_cnt_o++;
  endtask

  task automatic report_text(input string what);
    $display("Error at %0t: %s", $time, what);
    err_cnt_o++;
  endtask

  initial begin
    err_cnt_o    = 0;
    flush_hits_o = 0;
    for (int a = 0; a < int'(mem_pkg::NumWords); a++) begin
      model_valid[a] = 1'b0;
    end
  end

  ////////////////////////////////
  // per cycle checks
  ////////////////////////////////

  always @(posedge clk_i or negedge rst_ni) begin
    int  ngnt;
    logic wr;
    if (!rst_ni) begin
      rd_pend       = '0;
      rd_known      = '0;
      granted       = '0;
      prev_wr_grant = 1'b0;
      prev_flush    = 1'b0;
      for (int p = 0; p < int'(NumPorts); p++) begin
        for (int q = 0; q < int'(NumPorts); q++) begin
          rival_cnt[p][q] = 0;
        end
      end
    end else begin
      ngnt = $countones(gnt_o);
      wr   = 1'b0;
      if (ngnt > 1) begin
        report_text($sformatf("more than one port granted, gnt_o is %b", gnt_o));
      end
      // the bank sits out the cycle after a write
      if (prev_wr_grant && ngnt != 0) begin
        report_text("grant given in the recovery cycle after a write");
      end
      // a flush with every port waiting hands the next grant to port 0
      if (prev_flush && !prev_wr_grant && &busy_o) begin
        flush_hits_o++;
        if (gnt_o != NumPorts'(1)) begin
          report_value("gnt_o", 32'(1), 32'(gnt_o));
        end
      end
      for (int p = 0; p < int'(NumPorts); p++) begin
        if (rd_pend[p]) begin
          if (!rvalid_o[p]) begin
            report_value($sformatf("rvalid_o[%0d]", p), 32'(1), 32'(rvalid_o[p]));
          end else if (rd_known[p] && rdata_o[p] !== rd_exp[p]) begin
            report_value($sformatf("rdata_o[%0d]", p), 32'(rd_exp[p]), 32'(rdata_o[p]));
          end
        end else if (rvalid_o[p]) begin
          report_value($sformatf("rvalid_o[%0d]", p), 32'(0), 32'(rvalid_o[p]));
        end
        if (gnt_o[p] && !busy_o[p]) begin
          report_text($sformatf("port %0d granted without a pending request", p));
        end
        if (gnt_o[p] && granted[p]) begin
          report_text($sformatf("port %0d granted twice for one access", p));
        end
      end

      // apply the grants to the model in grant order
      rd_pend = '0;
      for (int q = 0; q < int'(NumPorts); q++) begin
        if (gnt_o[q] && busy_o[q]) begin
          if (held_we[q]) begin
            model_mem[held_addr[q]]   = held_wdata[q];
            model_valid[held_addr[q]] = 1'b1;
            wr = 1'b1;
          end else begin
            rd_pend[q]  = 1'b1;
            rd_exp[q]   = model_mem[held_addr[q]];
            rd_known[q] = model_valid[held_addr[q]];
          end
          for (int p = 0; p < int'(NumPorts); p++) begin
            if (p != q && fair_en_i && busy_o[p] && !gnt_o[p]) begin
              rival_cnt[p][q]++;
              if (rival_cnt[p][q] >= 2) begin
                report_text($sformatf("port %0d granted twice while port %0d waited", q, p));
              end
            end
          end
        end
      end

      // a port that is served or idle starts counting afresh
      for (int p = 0; p < int'(NumPorts); p++) begin
        if (gnt_o[p] || !busy_o[p] || flush_i) begin
          for (int q = 0; q < int'(NumPorts); q++) begin
            rival_cnt[p][q] = 0;
          end
        end
        if (req_i[p] && !busy_o[p]) begin
          held_we[p]    = we_i[p];
          held_addr[p]  = addr_i[p];
          held_wdata[p] = wdata_i[p];
        end
        // an idle port has nothing granted, a busy one keeps its grant
        if (!busy_o[p]) begin
          granted[p] = 1'b0;
        end else if (gnt_o[p]) begin
          granted[p] = 1'b1;
        end
      end
      prev_flush    = flush_i;
      prev_wr_grant = wr;
    end
  end

endmodule

`default_nettype wire

// ==== bench/tb_top.sv ====
/*
  testbench top for the shared memory
  clock, reset, LFSR stimulus, DUT, checker and the final report
*/
`default_nettype none

module tb_top;

  localparam int unsigned NumPorts = mem_pkg::NumPortsDefault;
  localparam int unsigned AW       = mem_pkg::AddrWidth;
  localparam int unsigned DW       = mem_pkg::DataWidth;

  logic                         clk;
  logic                         rst_n;
  logic                         flush;
  logic                         fair_en;
  logic [NumPorts-1:0]          req;
  logic [NumPorts-1:0]          we;
  logic [NumPorts-1:0][AW-1:0]  addr;
  logic [NumPorts-1:0][DW-1:0]  wdata;
  logic [NumPorts-1:0]          busy;
  logic [NumPorts-1:0]          gnt;
  logic [NumPorts-1:0]          rvalid;
  logic [NumPorts-1:0][DW-1:0]  rdata;

  int   chk_errors;
  int   flush_hits;
  int   tb_errors;
  int   tests_run;
  int   tests_failed;
  int   err_mark;
  bit   timed_out;
  logic [15:0] lfsr_q;

  shared_mem_top #(
    .NumPorts ( NumPorts ),
    .FairArb  ( 1'b1     )
  ) UUT (
    .clk_i    ( clk    ),
    .rst_ni   ( rst_n  ),
    .flush_i  ( flush  ),
    .req_i    ( req    ),
    .we_i     ( we     ),
    .addr_i   ( addr   ),
    .wdata_i  ( wdata  ),
    .busy_o   ( busy   ),
    .gnt_o    ( gnt    ),
    .rvalid_o ( rvalid ),
    .rdata_o  ( rdata  )
  );

  mem_checker #(
    .NumPorts ( NumPorts )
  ) i_checker (
    .clk_i        ( clk        ),
    .rst_ni       ( rst_n      ),
    .flush_i      ( flush      ),
    .fair_en_i    ( fair_en    ),
    .req_i        ( req        ),
    .we_i         ( we         ),
    .addr_i       ( addr       ),
    .wdata_i      ( wdata      ),
    .busy_o       ( busy       ),
    .gnt_o        ( gnt        ),
    .rvalid_o     ( rvalid     ),
    .rdata_o      ( rdata      ),
    .err_cnt_o    ( chk_errors ),
    .flush_hits_o ( flush_hits )
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // galois LFSR stepped once per bit with taps at 16, 14, 13 and 11
  function automatic logic [31:0] rand_bits(input int unsigned n);
    logic [31:0] val;
    logic        lsb;
    val = '0;
    for (int unsigned i = 0; i < n; i++) begin
      lsb    = lfsr_q[0];
      lfsr_q = lfsr_q >> 1;
      if (lsb) begin
        lfsr_q = lfsr_q ^ 16'hB400;
      end
      val = {val[30:0], lsb};
    end
    return val;
  endfunction

  ////////////////////////////////
  // waits and helpers
  ////////////////////////////////

  task automatic wait_port_idle(input int p);
    int n;
    n = 0;
    while (busy[p] && n < 100) begin
      @(negedge clk);
      n++;
    end
    if (busy[p]) begin
      $display("timeout: port %0d stayed busy for 100 cycles", p);
      timed_out = 1'b1;
    end
  endtask

  task automatic wait_all_idle();
    int n;
    n = 0;
    while (|busy && n < 100) begin
      @(negedge clk);
      n++;
    end
    if (|busy) begin
      $display("timeout: ports still busy after 100 cycles");
      timed_out = 1'b1;
    end
    // let the last read data and recovery cycle pass
    repeat (2) @(negedge clk);
  endtask

  task automatic issue(input int p, input logic w, input logic [AW-1:0] a, input logic [DW-1:0] d);
    wait_port_idle(p);
    if (!timed_out) begin
      req[p]   = 1'b1;
      we[p]    = w;
      addr[p]  = a;
      wdata[p] = d;
      @(negedge clk);
      req[p] = 1'b0;
    end
  endtask

  task automatic end_test(input string name);
    int now;
    now = chk_errors + tb_errors - err_mark;
    tests_run++;
    if (now != 0 || timed_out) begin
      tests_failed++;
    end
    $display("test %s finished with %0d errors", name, now);
    err_mark = chk_errors + tb_errors;
  endtask

  ////////////////////////////////
  // tests
  ////////////////////////////////

  task automatic test_reset();
    for (int c = 0; c < 4; c++) begin
      if (busy !== '0 || gnt !== '0 || rvalid !== '0) begin
        $display("Error at %0t: busy_o gnt_o rvalid_o expected 0 got %b %b %b",
                 $time, busy, gnt, rvalid);
        tb_errors++;
      end
      @(negedge clk);
    end
  endtask

  task automatic test_fill();
    for (int a = 0; a < int'(mem_pkg::NumWords); a++) begin
      issue(a % NumPorts, 1'b1, AW'(a), DW'(rand_bits(DW)));
    end
    wait_all_idle();
  endtask

  // mixed traffic with recovery cycles and flushes also exercises the rotation
  task automatic test_random();
    fair_en = 1'b1;
    for (int c = 0; c < 400; c++) begin
      flush = (rand_bits(4) == 0);
      for (int p = 0; p < int'(NumPorts); p++) begin
        req[p] = 1'b0;
        if (!busy[p] && rand_bits(1)) begin
          req[p]   = 1'b1;
          we[p]    = 1'(rand_bits(1));
          addr[p]  = AW'(rand_bits(AW));
          wdata[p] = DW'(rand_bits(DW));
        end
      end
      @(negedge clk);
    end
    req   = '0;
    flush = 1'b0;
    wait_all_idle();
    fair_en = 1'b0;
  endtask

  // every port keeps a read pending so the rotation must visit them all
  task automatic test_fairness();
    fair_en = 1'b1;
    for (int c = 0; c < 200; c++) begin
      for (int p = 0; p < int'(NumPorts); p++) begin
        req[p]  = !busy[p];
        we[p]   = 1'b0;
        addr[p] = AW'(rand_bits(AW));
      end
      @(negedge clk);
    end
    req = '0;
    wait_all_idle();
    fair_en = 1'b0;
  endtask

  task automatic test_flush();
    int hits_before;
    hits_before = flush_hits;
    for (int r = 0; r < 8 && !timed_out; r++) begin
      for (int p = 0; p < int'(NumPorts); p++) begin
        req[p]   = 1'b1;
        we[p]    = 1'(rand_bits(1));
        addr[p]  = AW'(rand_bits(AW));
        wdata[p] = DW'(rand_bits(DW));
      end
      flush = 1'b1;
      @(negedge clk);
      req   = '0;
      flush = 1'b0;
      wait_all_idle();
    end
    if (flush_hits - hits_before != 8) begin
      $display("Error at %0t: flush checks expected 8 got %0d", $time, flush_hits - hits_before);
      tb_errors++;
    end
  endtask

  initial begin
    lfsr_q       = 16'd8206;
    rst_n        = 1'b0;
    flush        = 1'b0;
    fair_en      = 1'b0;
    req          = '0;
    we           = '0;
    addr         = '0;
    wdata        = '0;
    tb_errors    = 0;
    tests_run    = 0;
    tests_failed = 0;
    err_mark     = 0;
    timed_out    = 1'b0;
    repeat (8) @(negedge clk);
    rst_n = 1'b1;

    test_reset();
    end_test("reset");
    if (!timed_out) begin
      test_fill();
      end_test("fill");
    end
    if (!timed_out) begin
      test_random();
      end_test("random");
    end
    if (!timed_out) begin
      test_fairness();
      end_test("fairness");
    end
    if (!timed_out) begin
      test_flush();
      end_test("flush");
    end

    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed,
             chk_errors + tb_errors);
    if (tests_failed == 0 && chk_errors + tb_errors == 0 && !timed_out) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb.f ====
design/mem_pkg.sv
design/mem_req_if.sv
design/lzc.sv
design/rr_arb_tree.sv
design/mem_port.sv
design/sram_bank.sv
design/shared_mem_top.sv
bench/mem_checker.sv
bench/tb_top.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
LINT      ?= --lint-only --timing -Wall
TOP       ?= tb_top
FILELIST  ?= tb.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
FAILMSG   ?= FAIL: see errors above
PASSMSG   ?= PASS: all tests

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJDIR)

run: build
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAILMSG)" $(LOG); then exit 1; fi
	@grep -q "$(PASSMSG)" $(LOG)

lint:
	$(VERILATOR) $(LINT) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJDIR) $(LOG)
